// ==== logic/lcdPkg.sv ====
package lcdPkg;

	////////////////////////////////////////////////////////////////////////////
	// Panel bus timing in clock cycles
	////////////////////////////////////////////////////////////////////////////

	localparam int rsCycles = 5;    // RS and data settle before the strobe.
	localparam int wrCycles = 10;   // Write strobe low time.
	localparam int rdCycles = 100;  // Read strobe low time, also read recovery.

	// The read strobe is the longest phase to count.
	localparam int cntWidth = $clog2(rdCycles);

	typedef logic [cntWidth-1:0] cycleCnt;

	////////////////////////////////////////////////////////////////////////////
	// Register map and panel commands
	////////////////////////////////////////////////////////////////////////////

	localparam logic [2:0] apbInstrOffset = 3'b000;  // RS low.
	localparam logic [2:0] apbDataOffset  = 3'b100;  // RS high.

	localparam logic [15:0] ramWriteCmd = 16'h2C00;  // Memory write.

	////////////////////////////////////////////////////////////////////////////
	// Handshake payloads
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic        isData;   // RS level.
		logic        isWrite;
		logic [15:0] wdata;
	} lcdReq;

	typedef struct packed {
		logic [15:0] rdata;    // Valid while ack is high after a read.
	} lcdRsp;

endpackage

// ==== logic/lcdBusTimer.sv ====
module lcdBusTimer (
	input  logic          clk,
	input  logic          nrst,
	input  logic          busReq,
	input  lcdPkg::lcdReq req,
	output logic          busAck,
	output lcdPkg::lcdRsp rsp,
	output logic          lcdCsel,
	output logic          lcdRs,
	output logic          lcdWr,
	output logic          lcdRd,
	input  logic [15:0]   lcdDataIn,
	output logic [15:0]   lcdDataOut,
	output logic [15:0]   lcdDataZ
);

	typedef enum logic [2:0] {
		tsIdle,
		tsSetup,
		tsAccess,
		tsAckWait,
		tsRecovery
	} timerState;

	timerState       state;
	lcdPkg::cycleCnt cnt;
	lcdPkg::cycleCnt rsLast;
	lcdPkg::cycleCnt accessLast;
	logic            curWrite;
	logic            accessDone;

	assign rsLast = lcdPkg::cycleCnt'(lcdPkg::rsCycles - 1);
	assign accessLast = curWrite ? lcdPkg::cycleCnt'(lcdPkg::wrCycles - 1) :
		lcdPkg::cycleCnt'(lcdPkg::rdCycles - 1);  // Recovery reuses the access length.
	assign accessDone = (state == tsAccess) && (cnt == accessLast);

	////////////////////////////////////////////////////////////////////////////
	// Phase sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state <= tsIdle;
			cnt <= '0;
			busAck <= 1'b0;
			lcdCsel <= 1'b1;
			lcdRs <= 1'b0;
			lcdWr <= 1'b1;
			lcdRd <= 1'b1;
			lcdDataZ <= 16'hFFFF;
		end else begin
			case (state)
				tsIdle: begin
					if (busReq) begin
						lcdRs <= req.isData;
						lcdDataZ <= req.isWrite ? 16'h0000 : 16'hFFFF;  // Drive writes only.
						cnt <= '0;
						state <= tsSetup;
					end
				end
				tsSetup: begin
					if (cnt == rsLast) begin
						cnt <= '0;
						lcdCsel <= 1'b0;
						lcdWr <= !curWrite;
						lcdRd <= curWrite;
						state <= tsAccess;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				tsAccess: begin
					if (accessDone) begin
						cnt <= '0;
						lcdWr <= 1'b1;  // Panel latches on this edge.
						lcdRd <= 1'b1;
						busAck <= 1'b1;
						state <= tsAckWait;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				tsAckWait: begin
					if (!busReq) begin
						busAck <= 1'b0;
						state <= tsRecovery;
					end
				end
				tsRecovery: begin
					if (cnt == accessLast) begin
						cnt <= '0;
						lcdCsel <= 1'b1;  // Back to idle pin levels.
						lcdRs <= 1'b0;
						lcdDataZ <= 16'hFFFF;
						state <= tsIdle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					state <= tsIdle;
				end
			endcase
		end
	end

	// Request payload and captured read word.
	always_ff @(posedge clk) begin
		if (state == tsIdle && busReq) begin
			curWrite <= req.isWrite;
			lcdDataOut <= req.wdata;
		end
		if (accessDone && !curWrite) begin
			rsp.rdata <= lcdDataIn;  // Sampled before RD rises.
		end
	end

endmodule

// ==== logic/lcdArbiter.sv ====
module lcdArbiter (
	input  logic          clk,
	input  logic          nrst,
	input  logic          apbReq,
	input  lcdPkg::lcdReq apbCmd,
	output logic          apbAck,
	input  logic          fillReq,
	input  lcdPkg::lcdReq fillCmd,
	output logic          fillAck,
	output logic          busReq,
	output lcdPkg::lcdReq busCmd,
	input  logic          busAck
);

	logic active;      // A peer holds the bus.
	logic owner;       // Set for the fill engine.
	logic lastWinner;  // Owner of the last finished transaction.
	logic pick;
	logic sel;
	logic winnerReq;

	// Alternate on a tie, otherwise take whoever asks.
	always_comb begin
		if (apbReq && fillReq) begin
			pick = !lastWinner;
		end else begin
			pick = fillReq;
		end
	end

	assign sel = active ? owner : pick;  // Grant in the same cycle from idle.
	assign winnerReq = sel ? fillReq : apbReq;

	assign busReq = winnerReq;
	assign busCmd = sel ? fillCmd : apbCmd;
	assign apbAck = busAck && !sel;
	assign fillAck = busAck && sel;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			active <= 1'b0;
			owner <= 1'b0;
			lastWinner <= 1'b1;  // APB wins the first tie.
		end else if (!active) begin
			if (apbReq || fillReq) begin
				active <= 1'b1;
				owner <= pick;
			end
		end else if (!winnerReq && !busAck) begin
			active <= 1'b0;  // Four-phase cycle closed.
			lastWinner <= owner;
		end
	end

endmodule

// ==== logic/apbLcdPort.sv ====
module apbLcdPort (
	input  logic          clk,
	input  logic          nrst,
	input  logic [31:0]   paddr,
	input  logic          psel,
	input  logic          penable,
	input  logic          pwrite,
	input  logic [31:0]   pwdata,
	output logic          pready,
	output logic          pslverr,
	output logic [31:0]   prdata,
	output logic          portReq,
	output lcdPkg::lcdReq portCmd,
	input  logic          portAck,
	input  lcdPkg::lcdRsp rsp
);

	logic [2:0] offset;
	logic       mapped;
	logic       access;
	logic       startReq;

	assign offset = paddr[2:0];
	assign mapped = (offset == lcdPkg::apbInstrOffset) || (offset == lcdPkg::apbDataOffset);
	assign access = psel && penable;

	// Wait for the previous ack to fall before asking again.
	assign startReq = access && mapped && !portReq && !portAck;

	////////////////////////////////////////////////////////////////////////////
	// APB response
	////////////////////////////////////////////////////////////////////////////

	assign pslverr = access && !mapped;
	assign pready = pslverr || (portReq && portAck);
	assign prdata = {16'h0000, rsp.rdata};

	////////////////////////////////////////////////////////////////////////////
	// Panel request
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			portReq <= 1'b0;
		end else if (!penable) begin
			portReq <= 1'b0;  // Master has taken pready.
		end else if (startReq) begin
			portReq <= 1'b1;
		end
	end

	// Held stable for the whole handshake.
	always_ff @(posedge clk) begin
		if (startReq) begin
			portCmd.isData <= (offset == lcdPkg::apbDataOffset);
			portCmd.isWrite <= pwrite;
			portCmd.wdata <= pwdata[15:0];
		end
	end

endmodule

// ==== logic/fillEngine.sv ====
module fillEngine (
	input  logic          clk,
	input  logic          nrst,
	input  logic          fillStart,
	input  logic [15:0]   pixelCount,
	input  logic [15:0]   color,
	output logic          busy,
	output logic          fillReq,
	output lcdPkg::lcdReq fillCmd,
	input  logic          fillAck
);

	typedef enum logic [1:0] {
		fsIdle,
		fsReq,
		fsWait
	} fillState;

	fillState    state;
	logic        sendCmd;    // Next word is the memory-write command.
	logic [15:0] remaining;  // Colour words still to send.
	logic [15:0] colorReg;
	logic        moreWords;

	assign busy = (state != fsIdle);
	assign fillReq = (state == fsReq);
	assign moreWords = sendCmd ? (remaining != 16'd0) : (remaining != 16'd1);

	always_comb begin
		fillCmd.isData = !sendCmd;
		fillCmd.isWrite = 1'b1;
		fillCmd.wdata = sendCmd ? lcdPkg::ramWriteCmd : colorReg;
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state <= fsIdle;
			sendCmd <= 1'b0;
			remaining <= 16'd0;
		end else begin
			case (state)
				fsIdle: begin
					if (fillStart) begin
						remaining <= pixelCount;
						sendCmd <= 1'b1;
						state <= fsReq;
					end
				end
				fsReq: begin
					if (fillAck) begin
						state <= fsWait;
					end
				end
				fsWait: begin
					if (!fillAck) begin
						if (!sendCmd) begin
							remaining <= remaining - 16'd1;
						end
						sendCmd <= 1'b0;
						state <= moreWords ? fsReq : fsIdle;  // Zero count stops after the command.
					end
				end
				default: begin
					state <= fsIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == fsIdle && fillStart) begin
			colorReg <= color;
		end
	end

endmodule

// ==== logic/lcdSubsystem.sv ====
module lcdSubsystem (
	input  logic        clk,
	input  logic        nrst,
	input  logic [31:0] paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic        pready,
	output logic        pslverr,
	output logic [31:0] prdata,
	input  logic        fillStart,
	input  logic [15:0] pixelCount,
	input  logic [15:0] color,
	output logic        busy,
	output logic        lcdNrst,
	output logic        lcdCsel,
	output logic        lcdRs,
	output logic        lcdWr,
	output logic        lcdRd,
	input  logic [15:0] lcdDataIn,
	output logic [15:0] lcdDataOut,
	output logic [15:0] lcdDataZ
);

	logic          apbReq;
	logic          apbAck;
	lcdPkg::lcdReq apbCmd;
	logic          fillReq;
	logic          fillAck;
	lcdPkg::lcdReq fillCmd;
	logic          busReq;
	logic          busAck;
	lcdPkg::lcdReq busCmd;
	lcdPkg::lcdRsp busRsp;

	assign lcdNrst = nrst;  // Panel reset follows the system reset.

	////////////////////////////////////////////////////////////////////////////
	// Bus peers
	////////////////////////////////////////////////////////////////////////////

	apbLcdPort apbPort (
		.clk(clk),
		.nrst(nrst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.pready(pready),
		.pslverr(pslverr),
		.prdata(prdata),
		.portReq(apbReq),
		.portCmd(apbCmd),
		.portAck(apbAck),
		.rsp(busRsp)
	);

	fillEngine fill (
		.clk(clk),
		.nrst(nrst),
		.fillStart(fillStart),
		.pixelCount(pixelCount),
		.color(color),
		.busy(busy),
		.fillReq(fillReq),
		.fillCmd(fillCmd),
		.fillAck(fillAck)
	);

	////////////////////////////////////////////////////////////////////////////
	// Arbitration and panel timing
	////////////////////////////////////////////////////////////////////////////

	lcdArbiter arbiter (
		.clk(clk),
		.nrst(nrst),
		.apbReq(apbReq),
		.apbCmd(apbCmd),
		.apbAck(apbAck),
		.fillReq(fillReq),
		.fillCmd(fillCmd),
		.fillAck(fillAck),
		.busReq(busReq),
		.busCmd(busCmd),
		.busAck(busAck)
	);

	lcdBusTimer timer (
		.clk(clk),
		.nrst(nrst),
		.busReq(busReq),
		.req(busCmd),
		.busAck(busAck),
		.rsp(busRsp),
		.lcdCsel(lcdCsel),
		.lcdRs(lcdRs),
		.lcdWr(lcdWr),
		.lcdRd(lcdRd),
		.lcdDataIn(lcdDataIn),
		.lcdDataOut(lcdDataOut),
		.lcdDataZ(lcdDataZ)
	);

endmodule

// ==== testbench/lcdPanelModel.sv ====
module lcdPanelModel (
	input  logic        nrst,
	input  logic        csel,
	input  logic        rs,
	input  logic        wr,
	input  logic        rd,
	input  logic [15:0] dataOut,
	input  logic [15:0] dataZ,
	output logic [15:0] dataIn
);

	logic [16:0] entries [0:63];         // {rs, data} per write strobe.
	int          count = 0;
	logic [15:0] readWord = 16'hA500;    // Next word returned on a read.

	assign dataIn = readWord;

	////////////////////////////////////////////////////////////////////////////
	// Write log and read data
	////////////////////////////////////////////////////////////////////////////

	// The panel latches on the rising edge of the write strobe.
	always @(posedge wr) begin
		if (nrst && !csel) begin
			entries[count] <= {rs, dataOut & ~dataZ};  // Undriven bits read as zero.
			count <= count + 1;
		end
	end

	always @(posedge rd) begin
		if (nrst && !csel) begin
			readWord <= readWord + 16'd1;
		end
	end

endmodule

// ==== testbench/lcdSubsystemTb.sv ====
module lcdSubsystemTb;

	localparam int resetCycles = 5;
	// One panel transaction from request to end of recovery, plus handshake slack.
	localparam int wrTxnCycles = 1 + lcdPkg::rsCycles + 2 * lcdPkg::wrCycles + 4;
	localparam int rdTxnCycles = 1 + lcdPkg::rsCycles + 2 * lcdPkg::rdCycles + 4;
	// 22 writes at most and 2 reads over all tests.
	localparam int timeoutCycles = resetCycles + 22 * wrTxnCycles + 2 * rdTxnCycles + 200;
	localparam logic [31:0] baseAddr = 32'h4000_0000;

	logic        clk;
	logic        nrst;
	logic [31:0] paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic        pready;
	logic        pslverr;
	logic [31:0] prdata;
	logic        fillStart;
	logic [15:0] pixelCount;
	logic [15:0] color;
	logic        busy;
	logic        lcdNrst;
	logic        lcdCsel;
	logic        lcdRs;
	logic        lcdWr;
	logic        lcdRd;
	logic [15:0] lcdDataIn;
	logic [15:0] lcdDataOut;
	logic [15:0] lcdDataZ;
	int          cycles = 0;

	lcdSubsystem UUT (
		.clk(clk),
		.nrst(nrst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.pready(pready),
		.pslverr(pslverr),
		.prdata(prdata),
		.fillStart(fillStart),
		.pixelCount(pixelCount),
		.color(color),
		.busy(busy),
		.lcdNrst(lcdNrst),
		.lcdCsel(lcdCsel),
		.lcdRs(lcdRs),
		.lcdWr(lcdWr),
		.lcdRd(lcdRd),
		.lcdDataIn(lcdDataIn),
		.lcdDataOut(lcdDataOut),
		.lcdDataZ(lcdDataZ)
	);

	lcdPanelModel panel (
		.nrst(lcdNrst),
		.csel(lcdCsel),
		.rs(lcdRs),
		.wr(lcdWr),
		.rd(lcdRd),
		.dataOut(lcdDataOut),
		.dataZ(lcdDataZ),
		.dataIn(lcdDataIn)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeoutCycles) begin
			$display("Timeout, the tests did not finish within %0d cycles", timeoutCycles);
			$display("Result: FAILED");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks and bus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkHex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkLog(input int idx, input logic [16:0] exp);
		checkHex("log entry", 32'(panel.entries[idx]), 32'(exp));
	endtask

	task automatic apbAccess(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(negedge clk);
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		psel = 1'b1;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		while (!pready) begin
			@(negedge clk);
		end
		rdata = prdata;
		err = pslverr;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data, input logic expErr);
		logic [31:0] rdata;
		logic        err;
		apbAccess(1'b1, addr, data, rdata, err);
		checkHex("pslverr", 32'(err), 32'(expErr));
	endtask

	task automatic apbRead(input logic [31:0] addr, input logic [31:0] exp);
		logic [31:0] rdata;
		logic        err;
		apbAccess(1'b0, addr, 32'h0, rdata, err);
		checkHex("pslverr", 32'(err), 32'h0);
		checkHex("prdata", rdata, exp);
	endtask

	task automatic startFill(input logic [15:0] count, input logic [15:0] colour);
		@(negedge clk);
		pixelCount = count;
		color = colour;
		fillStart = 1'b1;
		@(negedge clk);
		fillStart = 1'b0;
		checkTrue(busy, "Fill engine did not go busy after the start pulse.");
	endtask

	task automatic waitFillDone();
		while (busy) begin
			@(negedge clk);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic testReset();
		checkHex("lcdNrst", 32'(lcdNrst), 32'h1);
		checkHex("lcdCsel", 32'(lcdCsel), 32'h1);
		checkHex("lcdRs", 32'(lcdRs), 32'h0);
		checkHex("lcdWr", 32'(lcdWr), 32'h1);
		checkHex("lcdRd", 32'(lcdRd), 32'h1);
		checkHex("lcdDataZ", 32'(lcdDataZ), 32'hFFFF);
		checkHex("pready", 32'(pready), 32'h0);
		checkHex("busy", 32'(busy), 32'h0);
		checkHex("log length", 32'(panel.count), 32'h0);
	endtask

	task automatic testApbWrites();
		int          base;
		logic [31:0] v1;
		logic [31:0] v2;
		base = panel.count;
		v1 = $urandom;
		v2 = $urandom;
		apbWrite(baseAddr | 32'(lcdPkg::apbInstrOffset), v1, 1'b0);
		apbWrite(baseAddr | 32'(lcdPkg::apbDataOffset), v2, 1'b0);
		checkHex("log length", 32'(panel.count - base), 32'd2);
		checkLog(base, {1'b0, v1[15:0]});
		checkLog(base + 1, {1'b1, v2[15:0]});
	endtask

	task automatic testApbReads();
		apbRead(baseAddr | 32'(lcdPkg::apbDataOffset), 32'h0000_A500);
		apbRead(baseAddr | 32'(lcdPkg::apbDataOffset), 32'h0000_A501);
	endtask

	task automatic testFill(input int count, input logic [15:0] colour);
		int base;
		base = panel.count;
		startFill(16'(count), colour);
		waitFillDone();
		checkHex("log length", 32'(panel.count - base), 32'(count + 1));
		checkLog(base, {1'b0, 16'h2C00});
		for (int i = 1; i <= count; i++) begin
			checkLog(base + i, {1'b1, colour});
		end
	endtask

	task automatic testFillWithApb();
		int          count;
		int          base;
		int          apbSeen;
		logic [15:0] colour;
		logic [15:0] word;
		logic [16:0] entry;
		count = 2 + int'($urandom % 7);
		colour = 16'($urandom);
		word = ~colour;  // Keeps the APB word apart from the fill words.
		apbSeen = 0;
		base = panel.count;
		startFill(16'(count), colour);
		while (panel.count < base + 1) begin
			@(negedge clk);
		end
		apbWrite(baseAddr | 32'(lcdPkg::apbDataOffset), {16'hBEEF, word}, 1'b0);
		waitFillDone();
		checkHex("log length", 32'(panel.count - base), 32'(count + 2));
		checkLog(base, {1'b0, 16'h2C00});
		for (int i = 1; i < count + 2; i++) begin
			entry = panel.entries[base + i];
			if (entry == {1'b1, word}) begin
				apbSeen++;
			end else begin
				checkHex("fill word", 32'(entry), 32'({1'b1, colour}));
			end
		end
		checkHex("APB word count", 32'(apbSeen), 32'd1);
	endtask

	task automatic testBadOffset();
		int base;
		base = panel.count;
		// Bus released, so a stray request would reach the panel.
		while (!lcdCsel) begin
			@(negedge clk);
		end
		apbWrite(baseAddr | 32'h2, $urandom, 1'b1);
		repeat (lcdPkg::rsCycles + lcdPkg::wrCycles + 2) @(negedge clk);
		checkHex("log length", 32'(panel.count - base), 32'd0);
	endtask

	initial begin
		void'($urandom(32'h240b5e3f));
		clk = 1'b0;
		nrst = 1'b0;
		paddr = 32'h0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = 32'h0;
		fillStart = 1'b0;
		pixelCount = 16'h0;
		color = 16'h0;
		repeat (resetCycles) @(negedge clk);
		checkHex("lcdNrst", 32'(lcdNrst), 32'h0);
		nrst = 1'b1;
		@(negedge clk);
		testReset();
		testApbWrites();
		testApbReads();
		testFill(1 + int'($urandom % 8), 16'($urandom));
		testFill(0, 16'($urandom));  // Command only.
		testFillWithApb();
		testBadOffset();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== src.f ====
logic/lcdPkg.sv
logic/lcdBusTimer.sv
logic/lcdArbiter.sv
logic/apbLcdPort.sv
logic/fillEngine.sv
logic/lcdSubsystem.sv
testbench/lcdPanelModel.sv
testbench/lcdSubsystemTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module lcdSubsystemTb -f src.f

./obj_dir/VlcdSubsystemTb | tee /dev/stderr | grep "Result: PASSED" > /dev/null
